// ==== design/lxPkg.sv ====
`default_nettype none

package lxPkg;

  // instruction cache line geometry.
  localparam int lineWords = 4;
  localparam int lineBits = $clog2(lineWords);

  // 64 lines of 16 bytes make 1 KB.
  localparam int icLines = 64;
  localparam int icIndexBits = 6;
  localparam int icTagBits = 22; // address bits 31 to 10.

  // local data window storage.
  localparam int dwWords = 256;
  localparam int dwIndexBits = 8;

  typedef enum logic [2:0] {
    icClear,
    icIdle,
    icLookup,
    icRefill,
    icReturn
  } icState;

  typedef enum logic [1:0] {
    dwIdle,
    dwLocal,
    dwBus
  } dwState;

  typedef enum logic [1:0] {
    bmIdle,
    bmFill,
    bmData
  } bmState;

endpackage

`default_nettype wire

// ==== design/syncRam.sv ====
`timescale 1ns/100ps
`default_nettype none

module syncRam #(
  parameter int depth = 256,
  parameter int width = 32
) (
  input  logic                     sysClk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic [width-1:0]         wdata,
  output logic [width-1:0]         rdata
);

  logic [width-1:0] mem [depth];

  always_ff @(posedge sysClk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr]; // one cycle read latency.
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/instCache.sv ====
`timescale 1ns/100ps
`default_nettype none

module instCache (
  input  logic        sysClk,
  input  logic        rstN,
  input  logic        fetchReq,
  input  logic [29:0] fetchAddr,
  output logic        fetchAck,
  output logic [31:0] fetchData,
  output logic        fillReq,
  output logic [29:0] fillAddr,
  input  logic        fillAck,
  input  logic [31:0] busRdata
);

  import lxPkg::*;

  icState state;
  logic [icIndexBits-1:0] clrIdx;
  logic [lineBits-1:0] wordCnt;
  logic [lineBits-1:0] wrWord;
  logic fillDone;
  logic wrPend; // refill word waiting for the ram.
  logic [29:0] reqAddr;
  logic [31:0] keepWord;
  logic accept;
  logic hit;

  logic tagEn;
  logic tagWe;
  logic [icIndexBits-1:0] tagAddr;
  logic [icTagBits:0] tagWdata;
  logic [icTagBits:0] tagRdata;

  logic instEn;
  logic instWe;
  logic [icIndexBits+lineBits-1:0] instAddr;
  logic [31:0] instRdata;

  assign accept = (state == icIdle) && fetchReq && !fetchAck;
  assign hit = (tagRdata == {1'b1, reqAddr[29:8]}); // valid bit plus tag.

  assign fillReq = (state == icRefill) && !fillDone;
  assign fillAddr = {reqAddr[29:2], wordCnt};

  always_comb begin
    tagEn = 1'b0;
    tagWe = 1'b0;
    tagAddr = fetchAddr[7:2];
    tagWdata = {1'b1, reqAddr[29:8]};
    instEn = 1'b0;
    instWe = 1'b0;
    instAddr = fetchAddr[7:0];
    case (state)
      icClear: begin
        tagEn = 1'b1;
        tagWe = 1'b1;
        tagAddr = clrIdx;
        tagWdata = '0; // invalid entry.
      end
      icIdle: begin
        tagEn = accept;
        instEn = accept;
      end
      icRefill: begin
        instEn = wrPend;
        instWe = wrPend;
        instAddr = {reqAddr[7:2], wrWord};
        tagEn = fillDone && !wrPend; // tag goes in after the last word.
        tagWe = fillDone && !wrPend;
        tagAddr = reqAddr[7:2];
      end
      default: begin
      end
    endcase
  end

  syncRam #(.depth(icLines), .width(icTagBits + 1)) tagRam (
    .sysClk (sysClk),
    .en     (tagEn),
    .we     (tagWe),
    .addr   (tagAddr),
    .wdata  (tagWdata),
    .rdata  (tagRdata)
  );

  syncRam #(.depth(icLines * lineWords), .width(32)) instRam (
    .sysClk (sysClk),
    .en     (instEn),
    .we     (instWe),
    .addr   (instAddr),
    .wdata  (busRdata),
    .rdata  (instRdata)
  );

  always_ff @(posedge sysClk) begin
    if (!rstN) begin
      state <= icClear;
      clrIdx <= '0;
      wordCnt <= '0;
      fillDone <= 1'b0;
      wrPend <= 1'b0;
      fetchAck <= 1'b0;
    end else begin
      fetchAck <= 1'b0;
      wrPend <= fillAck; // bus data lands a cycle after the ack.
      case (state)
        icClear: begin
          clrIdx <= clrIdx + 1'b1;
          if (clrIdx == icIndexBits'(icLines - 1)) begin
            state <= icIdle;
          end
        end
        icIdle: begin
          if (accept) begin
            state <= icLookup;
          end
        end
        icLookup: begin
          if (hit) begin
            fetchAck <= 1'b1;
            state <= icIdle;
          end else begin
            wordCnt <= '0;
            fillDone <= 1'b0;
            state <= icRefill;
          end
        end
        icRefill: begin
          if (fillAck) begin
            wordCnt <= wordCnt + 1'b1;
            if (wordCnt == lineBits'(lineWords - 1)) begin
              fillDone <= 1'b1;
            end
          end
          if (fillDone && !wrPend) begin
            state <= icReturn;
          end
        end
        icReturn: begin
          fetchAck <= 1'b1;
          state <= icIdle;
        end
        default: state <= icIdle;
      endcase
    end
  end

  always_ff @(posedge sysClk) begin
    if (accept) begin
      reqAddr <= fetchAddr;
    end
    if (fillAck) begin
      wrWord <= wordCnt;
    end
    if (wrPend && (wrWord == reqAddr[1:0])) begin
      keepWord <= busRdata; // the word the core asked for.
    end
    if (state == icLookup) begin
      fetchData <= instRdata;
    end else if (state == icReturn) begin
      fetchData <= keepWord;
    end
  end

endmodule

`default_nettype wire

// ==== design/dataWindow.sv ====
`timescale 1ns/100ps
`default_nettype none

module dataWindow (
  input  logic        sysClk,
  input  logic        rstN,
  input  logic        dataReq,
  input  logic        dataWe,
  input  logic [29:0] dataAddr,
  input  logic [31:0] dataWdata,
  output logic        dataAck,
  output logic [31:0] dataRdata,
  input  logic [29:0] dwBase,
  input  logic [29:0] dwTop,
  output logic        memReq,
  output logic        memWe,
  output logic [29:0] memAddr,
  output logic [31:0] memWdata,
  input  logic        memAck,
  input  logic [31:0] busRdata
);

  import lxPkg::*;

  dwState state;
  logic inWin;
  logic [29:0] winOff;
  logic [dwIndexBits-1:0] winIdx;
  logic accept;
  logic winEn;
  logic [31:0] winRdata;
  logic [31:0] rdReg;
  logic busSel; // last ack came from the bus.

  assign inWin = (dataAddr >= dwBase) && (dataAddr < dwTop); // top excluded.
  assign winOff = dataAddr - dwBase;
  assign winIdx = winOff[dwIndexBits-1:0];

  assign accept = (state == dwIdle) && dataReq && !dataAck;
  assign winEn = accept && inWin;

  syncRam #(.depth(dwWords), .width(32)) winRam (
    .sysClk (sysClk),
    .en     (winEn),
    .we     (dataWe),
    .addr   (winIdx),
    .wdata  (dataWdata),
    .rdata  (winRdata)
  );

  // core holds the access until dataAck.
  assign memReq = (state == dwBus);
  assign memWe = dataWe;
  assign memAddr = dataAddr;
  assign memWdata = dataWdata;

  assign dataRdata = busSel ? busRdata : rdReg;

  always_ff @(posedge sysClk) begin
    if (!rstN) begin
      state <= dwIdle;
      dataAck <= 1'b0;
      busSel <= 1'b0;
    end else begin
      dataAck <= 1'b0;
      case (state)
        dwIdle: begin
          if (accept) begin
            state <= inWin ? dwLocal : dwBus;
          end
        end
        dwLocal: begin
          dataAck <= 1'b1;
          busSel <= 1'b0;
          state <= dwIdle;
        end
        dwBus: begin
          if (memAck) begin
            dataAck <= 1'b1;
            busSel <= 1'b1;
            state <= dwIdle;
          end
        end
        default: state <= dwIdle;
      endcase
    end
  end

  always_ff @(posedge sysClk) begin
    if (state == dwLocal) begin
      rdReg <= winRdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/busMaster.sv ====
`timescale 1ns/100ps
`default_nettype none

module busMaster (
  input  logic        sysClk,
  input  logic        rstN,
  input  logic        fillReq,
  input  logic [29:0] fillAddr,
  output logic        fillAck,
  input  logic        memReq,
  input  logic        memWe,
  input  logic [29:0] memAddr,
  input  logic [31:0] memWdata,
  output logic        memAck,
  output logic [31:0] busRdata,
  output logic        wbCyc,
  output logic        wbStb,
  output logic        wbWe,
  output logic [31:0] wbAdr,
  output logic [31:0] wbDatO,
  input  logic [31:0] wbDatI,
  input  logic        wbAck
);

  import lxPkg::*;

  bmState state;
  logic weReg;
  logic [31:0] adrReg;
  logic [31:0] datReg;

  // one word per bus cycle.
  assign wbCyc = (state != bmIdle);
  assign wbStb = (state != bmIdle);
  assign wbWe = weReg;
  assign wbAdr = adrReg;
  assign wbDatO = datReg;

  assign fillAck = (state == bmFill) && wbAck;
  assign memAck = (state == bmData) && wbAck;

  always_ff @(posedge sysClk) begin
    if (!rstN) begin
      state <= bmIdle;
      weReg <= 1'b0;
    end else begin
      case (state)
        bmIdle: begin
          if (memReq) begin
            state <= bmData; // data client has priority.
            weReg <= memWe;
          end else if (fillReq) begin
            state <= bmFill;
            weReg <= 1'b0;
          end
        end
        bmFill, bmData: begin
          if (wbAck) begin
            state <= bmIdle;
            weReg <= 1'b0;
          end
        end
        default: state <= bmIdle;
      endcase
    end
  end

  always_ff @(posedge sysClk) begin
    if (state == bmIdle) begin
      if (memReq) begin
        adrReg <= {memAddr, 2'b00};
        datReg <= memWdata;
      end else begin
        adrReg <= {fillAddr, 2'b00};
      end
    end
    if (wbCyc && wbAck) begin
      busRdata <= wbDatI; // shared by both clients.
    end
  end

endmodule

`default_nettype wire

// ==== design/lxMemSys.sv ====
`timescale 1ns/100ps
`default_nettype none

module lxMemSys (
  input  logic        sysClk,
  input  logic        rstN,
  input  logic        fetchReq,
  input  logic [29:0] fetchAddr,
  output logic        fetchAck,
  output logic [31:0] fetchData,
  input  logic        dataReq,
  input  logic        dataWe,
  input  logic [29:0] dataAddr,
  input  logic [31:0] dataWdata,
  output logic        dataAck,
  output logic [31:0] dataRdata,
  input  logic [29:0] dwBase,
  input  logic [29:0] dwTop,
  output logic        wbCyc,
  output logic        wbStb,
  output logic        wbWe,
  output logic [31:0] wbAdr,
  output logic [31:0] wbDatO,
  input  logic [31:0] wbDatI,
  input  logic        wbAck
);

  logic fillReq;
  logic [29:0] fillAddr;
  logic fillAck;
  logic memReq;
  logic memWe;
  logic [29:0] memAddr;
  logic [31:0] memWdata;
  logic memAck;
  logic [31:0] busRdata;

  instCache iCache (
    .sysClk    (sysClk),
    .rstN      (rstN),
    .fetchReq  (fetchReq),
    .fetchAddr (fetchAddr),
    .fetchAck  (fetchAck),
    .fetchData (fetchData),
    .fillReq   (fillReq),
    .fillAddr  (fillAddr),
    .fillAck   (fillAck),
    .busRdata  (busRdata)
  );

  dataWindow dWin (
    .sysClk    (sysClk),
    .rstN      (rstN),
    .dataReq   (dataReq),
    .dataWe    (dataWe),
    .dataAddr  (dataAddr),
    .dataWdata (dataWdata),
    .dataAck   (dataAck),
    .dataRdata (dataRdata),
    .dwBase    (dwBase),
    .dwTop     (dwTop),
    .memReq    (memReq),
    .memWe     (memWe),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .memAck    (memAck),
    .busRdata  (busRdata)
  );

  busMaster bMaster (
    .sysClk   (sysClk),
    .rstN     (rstN),
    .fillReq  (fillReq),
    .fillAddr (fillAddr),
    .fillAck  (fillAck),
    .memReq   (memReq),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memAck   (memAck),
    .busRdata (busRdata),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAdr    (wbAdr),
    .wbDatO   (wbDatO),
    .wbDatI   (wbDatI),
    .wbAck    (wbAck)
  );

endmodule

`default_nettype wire

// ==== bench/lxMemSys_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module lxMemSys_sva (
  input logic        sysClk,
  input logic        rstN,
  input logic        fetchReq,
  input logic        fetchAck,
  input logic        dataReq,
  input logic        dataAck,
  input logic [29:0] dataAddr,
  input logic [29:0] dwBase,
  input logic [29:0] dwTop,
  input logic        wbCyc,
  input logic        wbStb,
  input logic        wbAck,
  input logic [31:0] wbAdr
);

  logic busy; // data access in flight.
  logic start;
  logic inWin;
  int failCount = 0; // assertion failures so far.

  assign inWin = (dataAddr >= dwBase) && (dataAddr < dwTop);
  assign start = dataReq && !busy && !dataAck;

  always_ff @(posedge sysClk) begin
    if (!rstN) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (dataAck) begin
      busy <= 1'b0;
    end
  end

  stbNeedsCyc: assert property (@(posedge sysClk) disable iff (!rstN) wbStb |-> wbCyc)
    else begin
      $error("wbStb high without wbCyc");
      failCount++;
    end

  adrHeld: assert property (@(posedge sysClk) disable iff (!rstN)
    wbStb && !wbAck |=> $stable(wbAdr))
    else begin
      $error("wbAdr changed before wbAck");
      failCount++;
    end

  fetchAckNeedsReq: assert property (@(posedge sysClk) disable iff (!rstN)
    fetchAck |-> fetchReq)
    else begin
      $error("fetchAck without fetchReq");
      failCount++;
    end

  dataAckNeedsReq: assert property (@(posedge sysClk) disable iff (!rstN)
    dataAck |-> dataReq)
    else begin
      $error("dataAck without dataReq");
      failCount++;
    end

  // window hit acknowledges exactly two cycles later.
  winLatency: assert property (@(posedge sysClk) disable iff (!rstN)
    start && inWin |=> !dataAck ##1 dataAck)
    else begin
      $error("window access not acknowledged after two cycles");
      failCount++;
    end

endmodule

bind lxMemSys lxMemSys_sva handshakeChecks (
  .sysClk   (sysClk),
  .rstN     (rstN),
  .fetchReq (fetchReq),
  .fetchAck (fetchAck),
  .dataReq  (dataReq),
  .dataAck  (dataAck),
  .dataAddr (dataAddr),
  .dwBase   (dwBase),
  .dwTop    (dwTop),
  .wbCyc    (wbCyc),
  .wbStb    (wbStb),
  .wbAck    (wbAck),
  .wbAdr    (wbAdr)
);

`default_nettype wire

// ==== bench/lxMemSysTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lxMemSysTb;

  localparam logic [31:0] seed = 32'he8d15d84;
  localparam int timeoutCycles = 20000;
  localparam logic [29:0] winBase = 30'h100;
  localparam logic [29:0] winTop = 30'h200;

  logic sysClk = 1'b0;
  logic rstN;
  logic fetchReq;
  logic [29:0] fetchAddr;
  logic fetchAck;
  logic [31:0] fetchData;
  logic dataReq;
  logic dataWe;
  logic [29:0] dataAddr;
  logic [31:0] dataWdata;
  logic dataAck;
  logic [31:0] dataRdata;
  logic [29:0] dwBase;
  logic [29:0] dwTop;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [31:0] wbAdr;
  logic [31:0] wbDatO;
  logic [31:0] wbDatI;
  logic wbAck;

  logic [31:0] lfsr;
  logic [31:0] expMem [logic [29:0]]; // what the core has stored.
  logic [31:0] busMem [logic [29:0]];
  logic [31:0] lastAdr;
  logic [31:0] lastDat;
  logic inCycle;
  int waitLeft;
  int busCycles;
  int cycleCount;
  int errors;
  int checks;
  int testsRun;
  int testsFailed;

  lxMemSys UUT (.*);

  always #4 sysClk = ~sysClk;

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] modelWord(input logic [29:0] addr);
    logic [31:0] a;
    a = {2'b00, addr};
    return (a * 32'h9E3779B1) ^ (a << 7);
  endfunction

  function automatic logic [31:0] expectWord(input logic [29:0] addr);
    if (expMem.exists(addr)) begin
      return expMem[addr];
    end
    return modelWord(addr);
  endfunction

  // wishbone slave with 0 to 3 wait states per word.
  always @(negedge sysClk) begin
    logic [29:0] a;
    a = wbAdr[31:2];
    if (wbAck) begin
      wbAck = 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!inCycle) begin
        inCycle = 1'b1;
        busCycles++;
        waitLeft = int'(randBits(2));
      end
      if (waitLeft == 0) begin
        inCycle = 1'b0;
        wbAck = 1'b1;
        if (wbWe) begin
          busMem[a] = wbDatO;
          lastAdr = wbAdr;
          lastDat = wbDatO;
        end else begin
          wbDatI = busMem.exists(a) ? busMem[a] : modelWord(a);
        end
      end else begin
        waitLeft--;
      end
    end
  end

  task automatic fetchWord(input logic [29:0] addr, output logic [31:0] rd, output int lat);
    fetchAddr = addr;
    fetchReq = 1'b1;
    lat = 0;
    do begin
      @(negedge sysClk);
      lat++;
    end while (!fetchAck);
    rd = fetchData;
    @(negedge sysClk); // ack seen at the edge in between.
    fetchReq = 1'b0;
  endtask

  task automatic dataAccess(input logic we, input logic [29:0] addr, input logic [31:0] wd,
                            output logic [31:0] rd, output int lat);
    dataWe = we;
    dataAddr = addr;
    dataWdata = wd;
    dataReq = 1'b1;
    lat = 0;
    do begin
      @(negedge sysClk);
      lat++;
    end while (!dataAck);
    rd = dataRdata;
    @(negedge sysClk);
    dataReq = 1'b0;
  endtask

  task automatic checkFetch(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: fetchData got %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkData(input string sig, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h, expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic checkLatency(input int lat, input int want);
    checks++;
    if (lat != want) begin
      errors++;
      $display("at %0t an access took %0d cycles instead of %0d", $time, lat, want);
    end
  endtask

  task automatic checkBusCycles(input int mark, input int want);
    checks++;
    if (busCycles - mark != want) begin
      errors++;
      $display("at %0t saw %0d bus cycles, expected %0d", $time, busCycles - mark, want);
    end
  endtask

  task automatic finishTest(input string name, input int errMark);
    testsRun++;
    if (errors == errMark) begin
      $display("[%0t] test %s done, no errors", $time, name);
    end else begin
      testsFailed++;
      $display("[%0t] test %s done, %0d errors", $time, name, errors - errMark);
    end
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge sysClk);
      cycleCount++;
    end
    $display("timeout after %0d cycles, an access never completed", cycleCount);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [29:0] a;
    int lat;
    int errMark;
    int busMark;
    lfsr = seed;
    errors = 0;
    checks = 0;
    testsRun = 0;
    testsFailed = 0;
    busCycles = 0;
    inCycle = 1'b0;
    waitLeft = 0;
    rstN = 1'b0;
    fetchReq = 1'b0;
    fetchAddr = '0;
    dataReq = 1'b0;
    dataWe = 1'b0;
    dataAddr = '0;
    dataWdata = '0;
    dwBase = winBase;
    dwTop = winTop;
    wbDatI = '0;
    wbAck = 1'b0;
    repeat (8) @(negedge sysClk);
    rstN = 1'b1;
    @(negedge sysClk);
    if (fetchAck || dataAck || wbCyc || wbStb) begin
      errors++;
      $display("handshake outputs were not idle after reset");
    end

    errMark = errors;
    busMark = busCycles;
    for (int i = 0; i < 8; i++) begin
      fetchWord(30'h400 + 30'(i), rd, lat);
      checkFetch(rd, expectWord(30'h400 + 30'(i)));
    end
    checkBusCycles(busMark, 8); // two line refills.
    finishTest("coldFetch", errMark);

    errMark = errors;
    busMark = busCycles;
    for (int i = 0; i < 8; i++) begin
      fetchWord(30'h400 + 30'(i), rd, lat);
      checkFetch(rd, expectWord(30'h400 + 30'(i)));
      checkLatency(lat, 2);
    end
    checkBusCycles(busMark, 0);
    finishTest("fetchHit", errMark);

    errMark = errors;
    busMark = busCycles;
    fetchWord(30'h500, rd, lat); // same index, tag one higher.
    checkFetch(rd, expectWord(30'h500));
    fetchWord(30'h400, rd, lat);
    checkFetch(rd, expectWord(30'h400));
    checkBusCycles(busMark, 8);
    finishTest("eviction", errMark);

    errMark = errors;
    busMark = busCycles;
    for (int i = 0; i < 16; i++) begin
      wd = randBits(32);
      expMem[winBase + 30'(17 * i)] = wd;
      dataAccess(1'b1, winBase + 30'(17 * i), wd, rd, lat);
      checkLatency(lat, 2);
    end
    for (int i = 0; i < 16; i++) begin
      dataAccess(1'b0, winBase + 30'(17 * i), '0, rd, lat);
      checkData("dataRdata", rd, expectWord(winBase + 30'(17 * i)));
      checkLatency(lat, 2);
    end
    checkBusCycles(busMark, 0);
    finishTest("window", errMark);

    errMark = errors;
    busMark = busCycles;
    wd = 32'hC0DE5A01;
    expMem[30'h3000] = wd;
    dataAccess(1'b1, 30'h3000, wd, rd, lat);
    checkData("wbAdr", lastAdr, {30'h3000, 2'b00});
    checkData("wbDatO", lastDat, wd);
    dataAccess(1'b0, 30'h3000, '0, rd, lat);
    checkData("dataRdata", rd, expectWord(30'h3000));
    dataAccess(1'b0, winTop, '0, rd, lat); // top itself is outside.
    checkData("dataRdata", rd, expectWord(winTop));
    checkBusCycles(busMark, 3);
    finishTest("busData", errMark);

    errMark = errors;
    fork
      begin
        logic [31:0] frd;
        int flat;
        for (int k = 0; k < 4; k++) begin
          fetchWord(30'h900 + 30'(5 * k), frd, flat);
          checkFetch(frd, expectWord(30'h900 + 30'(5 * k)));
          fetchWord((30'h900 + 30'(5 * k)) ^ 30'h1, frd, flat);
          checkFetch(frd, expectWord((30'h900 + 30'(5 * k)) ^ 30'h1));
        end
      end
      begin
        logic [31:0] drd;
        int dlat;
        for (int k = 0; k < 4; k++) begin
          expMem[30'h4000 + 30'(k)] = 32'h5A5A0000 + k;
          dataAccess(1'b1, 30'h4000 + 30'(k), 32'h5A5A0000 + k, drd, dlat);
          dataAccess(1'b0, winBase + 30'(17 * k), '0, drd, dlat);
          checkData("dataRdata", drd, expectWord(winBase + 30'(17 * k)));
          checkLatency(dlat, 2);
          dataAccess(1'b0, 30'h4000 + 30'(k), '0, drd, dlat);
          checkData("dataRdata", drd, expectWord(30'h4000 + 30'(k)));
          dataAccess(1'b0, 30'h5000 + 30'(k), '0, drd, dlat);
          checkData("dataRdata", drd, expectWord(30'h5000 + 30'(k)));
        end
      end
    join
    finishTest("concurrent", errMark);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertions failed",
             testsRun, testsFailed, checks, errors, UUT.handshakeChecks.failCount);
    if (errors == 0 && UUT.handshakeChecks.failCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== lxMemSys.f ====
design/lxPkg.sv
design/syncRam.sv
design/instCache.sv
design/dataWindow.sv
design/busMaster.sv
design/lxMemSys.sv
bench/lxMemSys_sva.sv
bench/lxMemSysTb.sv

// ==== Bender.yml ====
package:
  name: lxMemSys

sources:
  - design/lxPkg.sv
  - design/syncRam.sv
  - design/instCache.sv
  - design/dataWindow.sv
  - design/busMaster.sv
  - design/lxMemSys.sv
  - target: simulation
    files:
      - bench/lxMemSys_sva.sv
      - bench/lxMemSysTb.sv
